//--- fe_config.svh
// fetch front end sizing, shared by the RTL and the testbench
// index widths are fixed by the hash layout, so changing them needs matching RTL edits
`ifndef FE_CONFIG_SVH
`define FE_CONFIG_SVH

// fetch address width
`define FE_ADDR_W 64

// global branch history length
`define FE_GHIST_W 16

// pattern table index, 256 entries per bank
`define FE_PHT_IDX_W 8

// target buffer index, 256 entries per way
`define FE_TB_IDX_W 8

// sequential advance in bytes per fetch block
`define FE_FETCH_STEP 16
`define FE_IP_LSB 4

`endif

//--- fe_addr_pkg.sv
// address and history types for the fetch front end
// history shifts left, the newest outcome sits in bit 0
`include "fe_config.svh"
`default_nettype none

package fe_addr_pkg;

  // one fetch block pointer
  typedef logic [`FE_ADDR_W-1:0] fe_addr_t;

  // global branch history
  typedef logic [`FE_GHIST_W-1:0] fe_ghist_t;

endpackage

`default_nettype wire

//--- fe_pred_pkg.sv
// prediction, slot and retire training types
// two branch slots per fetch block, slot 0 is the first branch
`include "fe_config.svh"
`default_nettype none

package fe_pred_pkg;

  // tag covers every address bit above the buffer index
  localparam int FE_TB_TAG_W = `FE_ADDR_W - `FE_IP_LSB - `FE_TB_IDX_W;

  // one taken bit per slot
  typedef logic [1:0] fe_pred_t;

  // branch slots present in the current block
  typedef enum logic [1:0] {
    SLOTS_NONE = 2'd0,
    SLOTS_ONE  = 2'd1,
    SLOTS_TWO  = 2'd2
  } fe_slots_e;

  // one retired branch
  typedef struct packed {
    logic                 valid;
    logic                 slot;
    logic                 taken;
    logic                 mispredict;
    fe_addr_pkg::fe_addr_t  src_ip;
    fe_addr_pkg::fe_addr_t  target;
    fe_addr_pkg::fe_ghist_t ghist;
  } fe_retire_s;

  // target buffer entry
  typedef struct packed {
    logic                   valid;
    logic [FE_TB_TAG_W-1:0] tag;
    fe_addr_pkg::fe_addr_t  target;
  } fe_tb_entry_s;

endpackage

`default_nettype wire

//--- pht_bank.sv
// one 2-bit pattern table, 256 entries, combinational read
// cleared by a sweep of one entry per cycle after reset, pred is undefined until ready
// retire updates are ignored during the sweep
`include "fe_config.svh"
`default_nettype none

module pht_bank #(
  parameter int HIST_BITS = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  fe_addr_pkg::fe_addr_t  lookup_ip,
  input  fe_addr_pkg::fe_ghist_t lookup_hist,
  input  fe_pred_pkg::fe_retire_s retire,
  output fe_pred_pkg::fe_pred_t  pred,
  output logic                   ready
);

  import fe_addr_pkg::*;
  import fe_pred_pkg::*;

  localparam int IDX_W   = `FE_PHT_IDX_W;
  localparam int IP_BITS = IDX_W - HIST_BITS;
  localparam int DEPTH   = 1 << IDX_W;

  fe_pred_t         table_q [DEPTH];
  logic [IDX_W-1:0] clr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] upd_idx;
  logic             do_flip;

  // history bits on top, pointer bits below
  function automatic logic [IDX_W-1:0] pht_hash(input fe_addr_t ip, input fe_ghist_t gh);
    return {gh[HIST_BITS-1:0], ip[`FE_IP_LSB +: IP_BITS]};
  endfunction

  assign rd_idx  = pht_hash(lookup_ip, lookup_hist);
  assign upd_idx = pht_hash(retire.src_ip, retire.ghist);
  assign do_flip = ready && retire.valid && retire.mispredict;

  // read sees contents from before this cycle's update
  assign pred = table_q[rd_idx];

  // clear sweep
  always_ff @(posedge clk) begin
    if (rst) begin
      clr_idx <= '0;
      ready   <= 1'b0;
    end else if (!ready) begin
      clr_idx <= clr_idx + 1'b1;
      // counter wraps on the last entry
      if (clr_idx == '1) begin
        ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!ready) begin
      table_q[clr_idx] <= '0;
    end else if (do_flip) begin
      // mispredict flips only the retiring slot
      table_q[upd_idx][retire.slot] <= ~table_q[upd_idx][retire.slot];
    end
  end

endmodule

`default_nettype wire

//--- target_buffer.sv
// two-way tagged target store, way n holds targets for branch slot n
// combinational read, write at the edge on a valid taken retire
`include "fe_config.svh"
`default_nettype none

module target_buffer (
  input  logic                    clk,
  input  logic                    rst,
  input  fe_addr_pkg::fe_addr_t   lookup_ip,
  input  fe_pred_pkg::fe_retire_s retire,
  output logic [1:0]              hit,
  output fe_addr_pkg::fe_addr_t   target0,
  output fe_addr_pkg::fe_addr_t   target1
);

  import fe_addr_pkg::*;
  import fe_pred_pkg::*;

  localparam int DEPTH   = 1 << `FE_TB_IDX_W;
  localparam int TAG_LSB = `FE_IP_LSB + `FE_TB_IDX_W;

  logic [FE_TB_TAG_W-1:0]  tag_mem [2][DEPTH];
  fe_addr_t                tgt_mem [2][DEPTH];
  logic [1:0][DEPTH-1:0]   vld;
  logic [`FE_TB_IDX_W-1:0] rd_idx;
  logic [`FE_TB_IDX_W-1:0] wr_idx;
  logic                    wr_en;
  fe_tb_entry_s            rd_entry [2];
  fe_tb_entry_s            wr_entry;

  assign rd_idx = lookup_ip[`FE_IP_LSB +: `FE_TB_IDX_W];
  assign wr_idx = retire.src_ip[`FE_IP_LSB +: `FE_TB_IDX_W];
  assign wr_en  = retire.valid && retire.taken;

  assign wr_entry = '{valid:  1'b1,
                      tag:    retire.src_ip[`FE_ADDR_W-1:TAG_LSB],
                      target: retire.target};

  for (genvar w = 0; w < 2; w++) begin : g_way
    assign rd_entry[w] = '{valid:  vld[w][rd_idx],
                           tag:    tag_mem[w][rd_idx],
                           target: tgt_mem[w][rd_idx]};
    // miss on an empty entry or a foreign tag
    assign hit[w] = rd_entry[w].valid && (rd_entry[w].tag == lookup_ip[`FE_ADDR_W-1:TAG_LSB]);
  end

  assign target0 = rd_entry[0].target;
  assign target1 = rd_entry[1].target;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld <= '0;
    end else if (wr_en) begin
      vld[retire.slot][wr_idx] <= wr_entry.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[retire.slot][wr_idx] <= wr_entry.tag;
      tgt_mem[retire.slot][wr_idx] <= wr_entry.target;
    end
  end

endmodule

`default_nettype wire

//--- fetch_sequencer.sv
// fetch pointer and history, one step per enabled cycle once the tables are ready
// a mispredict retire redirects regardless of fetch_en, outputs are registered
`include "fe_config.svh"
`default_nettype none

module fetch_sequencer (
  input  logic                    clk,
  input  logic                    rst,
  input  fe_addr_pkg::fe_addr_t   init_ip,
  input  logic                    fetch_en,
  input  fe_pred_pkg::fe_slots_e  slots,
  input  fe_pred_pkg::fe_retire_s retire,
  input  fe_pred_pkg::fe_pred_t   pred_a,
  input  fe_pred_pkg::fe_pred_t   pred_b,
  input  fe_pred_pkg::fe_pred_t   pred_c,
  input  logic                    tables_ready,
  input  logic [1:0]              hit,
  input  fe_addr_pkg::fe_addr_t   target0,
  input  fe_addr_pkg::fe_addr_t   target1,
  output fe_addr_pkg::fe_addr_t   lookup_ip,
  output fe_addr_pkg::fe_ghist_t  lookup_hist,
  output fe_addr_pkg::fe_addr_t   fetch_ip,
  output logic                    fetch_valid,
  output logic                    tbuf_miss
);

  import fe_addr_pkg::*;
  import fe_pred_pkg::*;

  fe_ghist_t ghist;
  fe_pred_t  pred;
  logic      take0;
  logic      take1;
  logic      redirect;
  logic      step;
  fe_addr_t  next_ip;
  fe_ghist_t next_hist;
  logic      next_miss;

  assign pred     = pred_a ^ pred_b ^ pred_c;
  assign take0    = pred[0] && (slots != SLOTS_NONE);
  // slot 1 only exists in two-branch blocks
  assign take1    = pred[1] && (slots == SLOTS_TWO);
  assign redirect = retire.valid && retire.mispredict;
  assign step     = fetch_valid && fetch_en;

  assign lookup_ip   = fetch_ip;
  assign lookup_hist = ghist;

  always_comb begin
    next_ip   = fetch_ip + `FE_ADDR_W'(`FE_FETCH_STEP);
    next_hist = ghist;
    next_miss = 1'b0;
    if (slots != SLOTS_NONE) begin
      next_hist = {ghist[`FE_GHIST_W-3:0], 2'b00};
    end
    if (take0) begin
      if (hit[0]) begin
        next_ip   = target0;
        next_hist = {ghist[`FE_GHIST_W-2:0], 1'b1};
      end else begin
        next_miss = 1'b1;
      end
    end else if (take1) begin
      if (hit[1]) begin
        // slot 0 not taken, slot 1 taken
        next_ip   = target1;
        next_hist = {ghist[`FE_GHIST_W-3:0], 2'b01};
      end else begin
        next_miss = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_ip    <= init_ip;
      ghist       <= '0;
      fetch_valid <= 1'b0;
      tbuf_miss   <= 1'b0;
    end else begin
      fetch_valid <= tables_ready;
      tbuf_miss   <= 1'b0;
      if (redirect) begin
        fetch_ip <= retire.target;
        ghist    <= retire.ghist;
      end else if (step) begin
        fetch_ip  <= next_ip;
        ghist     <= next_hist;
        tbuf_miss <= next_miss;
      end
    end
  end

endmodule

`default_nettype wire

//--- fe_top.sv
// fetch address generator, three pattern banks, target buffer and sequencer
// fetch_valid rises one cycle after all banks finish their clear sweep
`include "fe_config.svh"
`default_nettype none

module fe_top (
  input  logic                    clk,
  input  logic                    rst,
  input  fe_addr_pkg::fe_addr_t   init_ip,
  input  logic                    fetch_en,
  input  fe_pred_pkg::fe_slots_e  slots,
  input  fe_pred_pkg::fe_retire_s retire,
  output fe_addr_pkg::fe_addr_t   fetch_ip,
  output logic                    fetch_valid,
  output logic                    tbuf_miss
);

  import fe_addr_pkg::*;
  import fe_pred_pkg::*;

  fe_addr_t   lookup_ip;
  fe_ghist_t  lookup_hist;
  fe_pred_t   pred_a;
  fe_pred_t   pred_b;
  fe_pred_t   pred_c;
  logic       ready_a;
  logic       ready_b;
  logic       ready_c;
  logic [1:0] hit;
  fe_addr_t   target0;
  fe_addr_t   target1;

  // short, medium and long history mixes
  pht_bank #(.HIST_BITS(2)) bank_a (
    .clk(clk), .rst(rst), .lookup_ip(lookup_ip), .lookup_hist(lookup_hist),
    .retire(retire), .pred(pred_a), .ready(ready_a)
  );

  pht_bank #(.HIST_BITS(4)) bank_b (
    .clk(clk), .rst(rst), .lookup_ip(lookup_ip), .lookup_hist(lookup_hist),
    .retire(retire), .pred(pred_b), .ready(ready_b)
  );

  pht_bank #(.HIST_BITS(7)) bank_c (
    .clk(clk), .rst(rst), .lookup_ip(lookup_ip), .lookup_hist(lookup_hist),
    .retire(retire), .pred(pred_c), .ready(ready_c)
  );

  target_buffer u_tbuf (
    .clk(clk), .rst(rst), .lookup_ip(lookup_ip), .retire(retire),
    .hit(hit), .target0(target0), .target1(target1)
  );

  fetch_sequencer u_seq (
    .clk(clk), .rst(rst), .init_ip(init_ip), .fetch_en(fetch_en), .slots(slots),
    .retire(retire), .pred_a(pred_a), .pred_b(pred_b), .pred_c(pred_c),
    .tables_ready(ready_a & ready_b & ready_c), .hit(hit),
    .target0(target0), .target1(target1),
    .lookup_ip(lookup_ip), .lookup_hist(lookup_hist),
    .fetch_ip(fetch_ip), .fetch_valid(fetch_valid), .tbuf_miss(tbuf_miss)
  );

endmodule

`default_nettype wire

//--- fe_chk.sv
// assertions on fe_top fetch outputs, bound into every fe_top
// the cycle counter saturates, so the sweep rule only covers the first run after reset
`default_nettype none

module fe_chk (
  input logic                    clk,
  input logic                    rst,
  input logic                    fetch_en,
  input fe_pred_pkg::fe_retire_s retire,
  input fe_addr_pkg::fe_addr_t   fetch_ip,
  input logic                    fetch_valid,
  input logic                    tbuf_miss
);
  timeunit 1ns;
  timeprecision 100ps;

  import fe_pred_pkg::*;

  int unsigned since_rst;

  always_ff @(posedge clk) begin
    if (rst) begin
      since_rst <= 0;
    end else if (since_rst < 1000) begin
      since_rst <= since_rst + 1;
    end
  end

  a_sweep: assert property (@(posedge clk) disable iff (rst)
    since_rst < 256 |-> !fetch_valid)
    else $error("fetch_valid high during table clear");

  a_miss: assert property (@(posedge clk) disable iff (rst)
    tbuf_miss |-> fetch_valid)
    else $error("tbuf_miss without fetch_valid");

  // back-pressure holds the pointer
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (fetch_valid && !fetch_en && !(retire.valid && retire.mispredict)) |=> $stable(fetch_ip))
    else $error("fetch_ip moved under back-pressure");

endmodule

bind fe_top fe_chk chk (
  .clk(clk), .rst(rst), .fetch_en(fetch_en), .retire(retire),
  .fetch_ip(fetch_ip), .fetch_valid(fetch_valid), .tbuf_miss(tbuf_miss)
);

`default_nettype wire

//--- fe_tb.sv
// testbench for fe_top, a shadow model predicts fetch_ip and tbuf_miss every cycle
// retires are only sent once fetch_valid is high, stops at the first mismatch
`include "fe_config.svh"
`default_nettype none

module fe_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import fe_addr_pkg::*;
  import fe_pred_pkg::*;

  localparam int RESET_CYC = 8;
  localparam int SWEEP_CYC = 257;
  localparam int RAND_STEPS = 3000;
  // reset, sweep, directed steps, random steps and margin
  localparam int TIMEOUT = RESET_CYC + SWEEP_CYC + 40 + RAND_STEPS + 700;

  typedef struct packed {
    fe_addr_t  ip;
    fe_ghist_t hist;
    logic      miss;
  } exp_s;

  logic       clk;
  logic       rst;
  fe_addr_t   init_ip;
  logic       fetch_en;
  fe_slots_e  slots;
  fe_retire_s retire;
  fe_addr_t   fetch_ip;
  logic       fetch_valid;
  logic       tbuf_miss;

  // shadow state
  logic [1:0]  m_pht [3][256];
  bit          m_vld [2][256];
  logic [51:0] m_tag [2][256];
  fe_addr_t    m_tgt [2][256];
  fe_addr_t    m_ip;
  fe_ghist_t   m_hist;
  integer      seed;
  int          cycles;

  fe_top dut (
    .clk(clk), .rst(rst), .init_ip(init_ip), .fetch_en(fetch_en), .slots(slots),
    .retire(retire), .fetch_ip(fetch_ip), .fetch_valid(fetch_valid), .tbuf_miss(tbuf_miss)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_addr(input string name, input fe_addr_t got, input fe_addr_t exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_now($sformatf("ERROR: %s got %h expected %h", name, got, exp));
    end
  endtask

  // bank b mixes hb history bits over 8-hb pointer bits
  function automatic logic [7:0] pht_index(input int b, input fe_addr_t ip, input fe_ghist_t gh);
    int hb;
    hb = (b == 0) ? 2 : ((b == 1) ? 4 : 7);
    return 8'(((gh & ((1 << hb) - 1)) << (8 - hb)) | ((ip >> 4) & ((1 << (8 - hb)) - 1)));
  endfunction

  function automatic logic way_hit(input int w, input fe_addr_t ip);
    return m_vld[w][ip[11:4]] && (m_tag[w][ip[11:4]] == ip[63:12]);
  endfunction

  // expected state after the next edge, from state before that edge's retire
  function automatic exp_s predict(input fe_slots_e sl, input logic en, input fe_retire_s r);
    exp_s       e;
    logic [1:0] pr;
    logic       p0;
    logic       p1;
    e.ip = m_ip;
    e.hist = m_hist;
    e.miss = 1'b0;
    if (r.valid && r.mispredict) begin
      e.ip = r.target;
      e.hist = r.ghist;
    end else if (en) begin
      pr = 2'b00;
      for (int b = 0; b < 3; b++) begin
        pr = pr ^ m_pht[b][pht_index(b, m_ip, m_hist)];
      end
      p0 = pr[0] && (sl != SLOTS_NONE);
      p1 = pr[1] && (sl == SLOTS_TWO);
      e.ip = m_ip + 64'd16;
      if (sl != SLOTS_NONE) begin
        e.hist = {m_hist[13:0], 2'b00};
      end
      if (p0 && way_hit(0, m_ip)) begin
        e.ip = m_tgt[0][m_ip[11:4]];
        e.hist = {m_hist[14:0], 1'b1};
      end else if (p0) begin
        e.miss = 1'b1;
      end else if (p1 && way_hit(1, m_ip)) begin
        e.ip = m_tgt[1][m_ip[11:4]];
        e.hist = {m_hist[13:0], 2'b01};
      end else if (p1) begin
        e.miss = 1'b1;
      end
    end
    return e;
  endfunction

  task automatic train(input fe_retire_s r);
    logic [7:0] idx;
    if (r.valid && r.taken) begin
      m_vld[r.slot][r.src_ip[11:4]] = 1'b1;
      m_tag[r.slot][r.src_ip[11:4]] = r.src_ip[63:12];
      m_tgt[r.slot][r.src_ip[11:4]] = r.target;
    end
    if (r.valid && r.mispredict) begin
      for (int b = 0; b < 3; b++) begin
        idx = pht_index(b, r.src_ip, r.ghist);
        m_pht[b][idx][r.slot] = ~m_pht[b][idx][r.slot];
      end
    end
  endtask

  function automatic fe_retire_s mk_retire(input logic slot, input logic taken,
                                           input logic mispredict, input fe_addr_t src,
                                           input fe_addr_t target, input fe_ghist_t gh);
    return '{valid: 1'b1, slot: slot, taken: taken, mispredict: mispredict,
             src_ip: src, target: target, ghist: gh};
  endfunction

  // drive one cycle, then compare after the edge
  task automatic run_cycle(input fe_slots_e sl, input logic en, input fe_retire_s r);
    exp_s e;
    slots = sl;
    fetch_en = en;
    retire = r;
    e = predict(sl, en, r);
    @(posedge clk);
    #1;
    check_addr("fetch_ip", fetch_ip, e.ip);
    check_bit("tbuf_miss", tbuf_miss, e.miss);
    check_bit("fetch_valid", fetch_valid, 1'b1);
    train(r);
    m_ip = e.ip;
    m_hist = e.hist;
  endtask

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the test did not finish within %0d cycles", TIMEOUT);
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    fe_addr_t   p;
    fe_addr_t   t0;
    fe_addr_t   t1;
    fe_ghist_t  h;
    fe_retire_s r;
    int         cnt;
    int         k;
    seed = 32'hb97530d0;
    rst = 1'b1;
    init_ip = 64'h0000_1234_5678_9a00;
    fetch_en = 1'b0;
    slots = SLOTS_NONE;
    retire = '0;
    for (int i = 0; i < 256; i++) begin
      for (int b = 0; b < 3; b++) begin
        m_pht[b][i] = 2'b00;
      end
      m_vld[0][i] = 1'b0;
      m_vld[1][i] = 1'b0;
    end
    repeat (RESET_CYC) @(posedge clk);
    #1;
    check_addr("fetch_ip", fetch_ip, init_ip);
    check_bit("fetch_valid", fetch_valid, 1'b0);
    check_bit("tbuf_miss", tbuf_miss, 1'b0);
    rst = 1'b0;
    cnt = 0;
    // 256 sweep cycles, fetch_valid one cycle later
    while (!fetch_valid) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (cnt != SWEEP_CYC) begin
      fail_now($sformatf("fetch_valid rose %0d cycles after reset, not %0d", cnt, SWEEP_CYC));
    end
    check_addr("fetch_ip", fetch_ip, init_ip);
    m_ip = init_ip;
    m_hist = '0;

    // empty tables, then back-pressure, then redirect with fetch_en low
    repeat (12) run_cycle(SLOTS_TWO, 1'b1, '0);
    repeat (4) run_cycle(SLOTS_ONE, 1'b0, '0);
    run_cycle(SLOTS_NONE, 1'b0,
              mk_retire(1'b0, 1'b0, 1'b1, m_ip, 64'h0000_0000_0002_0000, 16'h00a5));

    p = 64'h0000_0000_8000_0340;
    t0 = 64'h0000_0000_9000_0100;
    t1 = 64'h0000_0000_a000_0200;
    h = 16'h5a3c;
    // slot 0 trained target
    run_cycle(SLOTS_NONE, 1'b0, mk_retire(1'b0, 1'b1, 1'b0, p, t0, h));
    run_cycle(SLOTS_NONE, 1'b0, mk_retire(1'b0, 1'b0, 1'b1, p, p, h));
    run_cycle(SLOTS_ONE, 1'b1, '0);
    check_addr("fetch_ip", fetch_ip, t0);
    // same index, foreign tag
    run_cycle(SLOTS_NONE, 1'b0, mk_retire(1'b1, 1'b0, 1'b1, p + 64'h1000, p + 64'h1000, h));
    run_cycle(SLOTS_ONE, 1'b1, '0);
    check_bit("tbuf_miss", tbuf_miss, 1'b1);
    check_addr("fetch_ip", fetch_ip, p + 64'h1010);
    // slot 1, only with two slots
    run_cycle(SLOTS_NONE, 1'b0, mk_retire(1'b1, 1'b1, 1'b0, p, t1, h));
    run_cycle(SLOTS_NONE, 1'b0, mk_retire(1'b0, 1'b0, 1'b1, p, p, h));
    run_cycle(SLOTS_ONE, 1'b1, '0);
    check_addr("fetch_ip", fetch_ip, p + 64'h10);
    run_cycle(SLOTS_NONE, 1'b0, mk_retire(1'b0, 1'b0, 1'b1, p + 64'h10, p, h));
    run_cycle(SLOTS_TWO, 1'b1, '0);
    check_addr("fetch_ip", fetch_ip, t1);

    // random mix, targets kept in a small window so entries get reused
    for (int i = 0; i < RAND_STEPS; i++) begin
      r = '0;
      k = $unsigned($random(seed)) % 16;
      if (k < 4) begin
        r = mk_retire(1'($random(seed)), 1'b1, k == 0, m_ip,
                      64'h0001_0000 + 64'(($unsigned($random(seed)) % 64) * 16)
                      + ((k == 1) ? 64'h1000 : 64'h0),
                      (k == 0) ? fe_ghist_t'($random(seed)) : m_hist);
      end else if (k == 4) begin
        r = mk_retire(1'($random(seed)), 1'b0, 1'b1, m_ip,
                      64'h0001_0000 + 64'(($unsigned($random(seed)) % 64) * 16), m_hist);
      end
      run_cycle(fe_slots_e'($unsigned($random(seed)) % 3),
                ($unsigned($random(seed)) % 4) != 0, r);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
fe_addr_pkg.sv
fe_pred_pkg.sv
pht_bank.sv
target_buffer.sv
fetch_sequencer.sv
fe_top.sv
fe_chk.sv
fe_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fe_tb \
  -f flist.f -o vfe_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/vfe_tb > sim.log 2>&1 \
  || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
